/* rtl/ex_defines.svh */
//******************************
// Execution pipe parameters
//******************************
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// Datapath width of operands and results
`define EX_DW 64

// Load/store address width
`define EX_AW 64

// Instruction address, counted in 4-byte words
`define EX_PC_W 62

// Physical register file address
`define EX_PRF_AW 6

// ROB slot id and commit bank
`define EX_ROB_AW 4
`define EX_BANK_W 2

// Fault code carried from fetch and decode
`define EX_FE_W 4

// Arithmetic shift right
// 0 falls back to a logical shift for SRA
`define EX_ENABLE_ASR 1

`endif

/* rtl/ex_pkg.sv */
//******************************
// Execution pipe types
//******************************
`include "ex_defines.svh"

package ex_pkg;

   // ALU operations
   // ADD and SUB go through the shared adder
   typedef enum logic [2:0] {
      ADD,
      SUB,
      AND,
      OR,
      XOR,
      SLL,
      SRL,
      SRA
   } alu_op_e;

   // Branch unit operations
   // NONE for every op that is not a jump or branch
   typedef enum logic [3:0] {
      NONE,
      JAL,
      JALR,
      BEQ,
      BNE,
      BGT,
      BGTU,
      BLE,
      BLEU
   } bru_op_e;

   // Result handed to writeback
   typedef struct packed {
      logic [`EX_ROB_AW-1:0] rob_id;
      logic [`EX_BANK_W-1:0] rob_bank;
      // Register write, before the valid gate
      logic                  prf_we;
      logic [`EX_PRF_AW-1:0] prf_addr;
      logic [`EX_DW-1:0]     prf_data;
      // Misprediction flush request
      logic                  fls;
      // Nonzero fault code
      logic                  exc;
      // Address, or fault code on an exception
      logic [`EX_AW-1:0]     opera;
      logic [`EX_DW-1:0]     operb;
      // Redirect target on a flush
      logic [`EX_PC_W-1:0]   fls_tgt;
   } wb_payload_t;

endpackage

/* rtl/ex_add_if.sv */
//******************************
// Shared adder bus
//******************************
`timescale 1ns/1ns
`include "ex_defines.svh"

interface ex_add_if;
   // Operands, b already chosen between operand2 and imm
   logic [`EX_DW-1:0] a;
   logic [`EX_DW-1:0] b;
   // Subtract instead of add
   logic              sub;
   // Results
   logic [`EX_DW-1:0] sum;
   logic              carry;
   logic              overflow;

   // Side that owns the adder
   modport provider (output a, b, sub, sum, carry, overflow);

   // Functional units that only consume the result
   modport user (input a, b, sum, carry, overflow);
endinterface

/* rtl/ex_alu.sv */
//******************************
// Integer ALU
//******************************
`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_alu (
   input  ex_pkg::alu_op_e  op,
   input  logic [`EX_DW-1:0] operand1,
   input  logic [`EX_DW-1:0] operand2,
   ex_add_if.user            add,
   output logic [`EX_DW-1:0] result
);
   // Shift amount width, 6 bits for a 64-bit datapath
   localparam int SHW = $clog2(`EX_DW);

   logic [SHW-1:0]    shamt;
   logic [`EX_DW-1:0] asr_res;
   logic [`EX_DW-1:0] sra_res;

   assign shamt = operand2[SHW-1:0];

   // Arithmetic shift with sign fill
   assign asr_res = $signed(operand1) >>> shamt;

   // Sign fill only when the arithmetic shifter is built
   assign sra_res = (`EX_ENABLE_ASR != 0) ? asr_res : (operand1 >> shamt);

   always_comb begin
      case (op)
         // Sum already reflects the subtract select
         ex_pkg::ADD: result = add.sum;
         ex_pkg::SUB: result = add.sum;
         // Bitwise logic
         ex_pkg::AND: result = operand1 & operand2;
         ex_pkg::OR:  result = operand1 | operand2;
         ex_pkg::XOR: result = operand1 ^ operand2;
         // Shifts
         ex_pkg::SLL: result = operand1 << shamt;
         ex_pkg::SRL: result = operand1 >> shamt;
         ex_pkg::SRA: result = sra_res;
         default:     result = add.sum;
      endcase
   end

endmodule

/* rtl/ex_bru.sv */
//******************************
// Branch unit
//******************************
`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_bru (
   input  ex_pkg::bru_op_e     op,
   input  logic [`EX_PC_W-1:0] pc,
   input  logic [`EX_PC_W-1:0] npc,
   // Branch offset, counted in words
   input  logic [`EX_PC_W-1:0] imm,
   ex_add_if.user              add,
   output logic                taken,
   output logic [`EX_PC_W-1:0] tgt,
   output logic [`EX_DW-1:0]   link,
   output logic                link_valid
);
   logic zero;
   logic sign;
   logic gt_s;
   logic gt_u;
   logic is_jump;

   // Flags of operand1 - operand2
   assign zero = ~|add.sum;
   assign sign = add.sum[`EX_DW-1];

   // Signed: difference positive once overflow is undone
   assign gt_s = ~(sign ^ add.overflow) & ~zero;

   // Unsigned: no borrow and not equal
   assign gt_u = add.carry & ~zero;

   assign is_jump = (op == ex_pkg::JAL) | (op == ex_pkg::JALR);

   // Condition per opcode
   always_comb begin
      case (op)
         ex_pkg::JAL:  taken = 1'b1;
         ex_pkg::JALR: taken = 1'b1;
         ex_pkg::BEQ:  taken = zero;
         ex_pkg::BNE:  taken = ~zero;
         ex_pkg::BGT:  taken = gt_s;
         ex_pkg::BGTU: taken = gt_u;
         ex_pkg::BLE:  taken = ~gt_s;
         ex_pkg::BLEU: taken = ~gt_u;
         // Not a control transfer
         default:      taken = 1'b0;
      endcase
   end

   // JALR target from register plus imm on the shared adder
   // everything else is PC relative
   assign tgt = (op == ex_pkg::JALR) ? add.sum[`EX_PC_W-1:0] : (pc + imm);

   // Return address goes to the destination register
   assign link       = {{(`EX_DW - `EX_PC_W){1'b0}}, npc};
   assign link_valid = is_jump;

endmodule

/* rtl/ex_stage_buf.sv */
//******************************
// Writeback stage buffer
//******************************
`timescale 1ns/1ns

module ex_stage_buf (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                flush,
   // Upstream
   input  logic                in_valid,
   output logic                in_ready,
   input  ex_pkg::wb_payload_t in_data,
   // Downstream
   output logic                out_valid,
   input  logic                out_ready,
   output ex_pkg::wb_payload_t out_data
);
   logic                valid_q;
   ex_pkg::wb_payload_t data_q;
   logic                load;

   // Free when empty or when the held item leaves this cycle
   assign in_ready = ~valid_q | out_ready;

   // Flush wins over a capture in the same cycle
   assign load = in_valid & in_ready & ~flush;

   // Valid flag
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= 1'b0;
      end else if (flush) begin
         valid_q <= 1'b0;
      end else if (in_ready) begin
         valid_q <= in_valid;
      end
   end

   // Payload, only meaningful while valid_q is set
   always_ff @(posedge clk) begin
      if (load) begin
         data_q <= in_data;
      end
   end

   assign out_valid = valid_q;
   assign out_data  = data_q;

endmodule

/* rtl/ex_pipe.sv */
//******************************
// Integer execution pipe
//******************************
`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_pipe (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  flush,
   // Issued micro-op
   input  logic                  ex_valid,
   input  ex_pkg::alu_op_e       ex_alu_op,
   input  ex_pkg::bru_op_e       ex_bru_op,
   input  logic                  ex_lsu_op,
   input  logic                  ex_epu_op,
   input  logic [`EX_FE_W-1:0]   ex_fe,
   input  logic                  ex_pred_taken,
   input  logic [`EX_PC_W-1:0]   ex_pred_tgt,
   input  logic [`EX_PC_W-1:0]   ex_pc,
   input  logic [`EX_DW-1:0]     ex_imm,
   input  logic [`EX_DW-1:0]     ex_operand1,
   input  logic [`EX_DW-1:0]     ex_operand2,
   input  logic [`EX_PRF_AW-1:0] ex_prd,
   input  logic                  ex_prd_we,
   input  logic [`EX_ROB_AW-1:0] ex_rob_id,
   input  logic [`EX_BANK_W-1:0] ex_rob_bank,
   output logic                  ex_ready,
   // Writeback
   input  logic                  wb_ready,
   output logic                  wb_valid,
   output logic [`EX_ROB_AW-1:0] wb_rob_id,
   output logic [`EX_BANK_W-1:0] wb_rob_bank,
   output logic                  prf_we,
   output logic [`EX_PRF_AW-1:0] prf_addr,
   output logic [`EX_DW-1:0]     prf_data,
   output logic                  wb_fls,
   output logic                  wb_exc,
   output logic [`EX_AW-1:0]     wb_opera,
   output logic [`EX_DW-1:0]     wb_operb,
   output logic [`EX_PC_W-1:0]   wb_fls_tgt
);
   ex_add_if add_bus ();

   logic                  agu_en;
   logic                  is_cond_br;
   logic [`EX_DW-1:0]     b_eff;
   logic [`EX_PC_W-1:0]   npc;
   logic [`EX_DW-1:0]     alu_res;
   logic                  b_taken;
   logic [`EX_PC_W-1:0]   b_tgt;
   logic [`EX_DW-1:0]     bru_link;
   logic                  bru_link_valid;
   logic                  mispred;
   logic                  exc;
   logic [`EX_AW-1:0]     lsa;
   ex_pkg::wb_payload_t   s1i_data;
   ex_pkg::wb_payload_t   s1o_data;

   // Address forming ops and JALR add the immediate
   assign agu_en = ex_lsu_op | ex_epu_op | (ex_bru_op == ex_pkg::JALR);

   assign is_cond_br = (ex_bru_op == ex_pkg::BEQ)  | (ex_bru_op == ex_pkg::BNE) |
                       (ex_bru_op == ex_pkg::BGT)  | (ex_bru_op == ex_pkg::BGTU) |
                       (ex_bru_op == ex_pkg::BLE)  | (ex_bru_op == ex_pkg::BLEU);

   // Shared adder, also serves the branch compare
   assign add_bus.a   = ex_operand1;
   assign add_bus.b   = agu_en ? ex_imm : ex_operand2;
   assign add_bus.sub = (ex_alu_op == ex_pkg::SUB) | is_cond_br;

   // Two's complement subtract: invert and carry in
   assign b_eff = add_bus.sub ? ~add_bus.b : add_bus.b;
   assign {add_bus.carry, add_bus.sum} = {1'b0, add_bus.a} + {1'b0, b_eff} +
                                         {{`EX_DW{1'b0}}, add_bus.sub};
   assign add_bus.overflow = (add_bus.a[`EX_DW-1] == b_eff[`EX_DW-1]) &
                             (add_bus.sum[`EX_DW-1] != add_bus.a[`EX_DW-1]);

   // Fall-through PC, one word on
   assign npc = ex_pc + {{(`EX_PC_W-1){1'b0}}, 1'b1};

   ex_alu u_alu (
      .op       (ex_alu_op),
      .operand1 (ex_operand1),
      .operand2 (ex_operand2),
      .add      (add_bus),
      .result   (alu_res)
   );

   ex_bru u_bru (
      .op         (ex_bru_op),
      .pc         (ex_pc),
      .npc        (npc),
      .imm        (ex_imm[`EX_PC_W-1:0]),
      .add        (add_bus),
      .taken      (b_taken),
      .tgt        (b_tgt),
      .link       (bru_link),
      .link_valid (bru_link_valid)
   );

   // Load/store address straight from the adder
   assign lsa = add_bus.sum[`EX_AW-1:0];

   // Direction wrong, or taken to the wrong place
   assign mispred = (b_taken ^ ex_pred_taken) | (b_taken & (b_tgt != ex_pred_tgt));

   assign exc = |ex_fe;

   // Payload into the stage register
   always_comb begin
      s1i_data.rob_id   = ex_rob_id;
      s1i_data.rob_bank = ex_rob_bank;
      // LSU and EPU results come later, at commit
      s1i_data.prf_we   = ex_prd_we & ~(ex_lsu_op | ex_epu_op);
      s1i_data.prf_addr = ex_prd;
      s1i_data.prf_data = bru_link_valid ? bru_link : alu_res;
      s1i_data.fls      = mispred;
      s1i_data.exc      = exc;
      // Fault code replaces the address on an exception
      s1i_data.opera    = exc ? {{(`EX_AW - `EX_FE_W){1'b0}}, ex_fe} : lsa;
      s1i_data.operb    = ex_operand2;
      s1i_data.fls_tgt  = b_taken ? b_tgt : npc;
   end

   ex_stage_buf u_buf (
      .clk       (clk),
      .arst_n    (arst_n),
      .flush     (flush),
      .in_valid  (ex_valid),
      .in_ready  (ex_ready),
      .in_data   (s1i_data),
      .out_valid (wb_valid),
      .out_ready (wb_ready),
      .out_data  (s1o_data)
   );

   // Unpack to the writeback ports
   assign wb_rob_id   = s1o_data.rob_id;
   assign wb_rob_bank = s1o_data.rob_bank;
   // Stale payload must not write the register file
   assign prf_we      = s1o_data.prf_we & wb_valid;
   assign prf_addr    = s1o_data.prf_addr;
   assign prf_data    = s1o_data.prf_data;
   assign wb_fls      = s1o_data.fls;
   assign wb_exc      = s1o_data.exc;
   assign wb_opera    = s1o_data.opera;
   assign wb_operb    = s1o_data.operb;
   assign wb_fls_tgt  = s1o_data.fls_tgt;

endmodule

/* dv/ex_pipe_assertions.sv */
//******************************
// Execution pipe protocol checks
//******************************
`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_pipe_assertions #(
   parameter int PW = `EX_ROB_AW + `EX_BANK_W + `EX_PRF_AW + 3 +
                      2 * `EX_DW + `EX_AW + `EX_PC_W
) (
   input logic          clk,
   input logic          arst_n,
   input logic          flush,
   input logic          ex_ready,
   input logic          wb_valid,
   input logic          wb_ready,
   input logic          prf_we,
   // All writeback outputs packed together
   input logic [PW-1:0] payload
);

   // Empty pipe during reset and on release
   a_reset_idle: assert property (
      @(posedge clk) (!arst_n || $rose(arst_n)) |-> (ex_ready && !wb_valid)
   ) else $error("pipe not empty and ready around reset");

   // Held result must not move while writeback stalls
   a_hold_stable: assert property (
      @(posedge clk) disable iff (!arst_n)
      (wb_valid && !wb_ready && !flush) |=> (wb_valid && $stable(payload))
   ) else $error("writeback payload changed under back-pressure");

   // No register write without a valid result
   a_we_valid: assert property (
      @(posedge clk) disable iff (!arst_n) prf_we |-> wb_valid
   ) else $error("prf_we high while wb_valid low");

endmodule

bind ex_pipe ex_pipe_assertions u_assert (
   .clk      (clk),
   .arst_n   (arst_n),
   .flush    (flush),
   .ex_ready (ex_ready),
   .wb_valid (wb_valid),
   .wb_ready (wb_ready),
   .prf_we   (prf_we),
   .payload  ({wb_rob_id, wb_rob_bank, prf_we, prf_addr, prf_data, wb_fls, wb_exc,
               wb_opera, wb_operb, wb_fls_tgt})
);

/* dv/ex_pipe_tb.sv */
//******************************
// Execution pipe testbench
//******************************
`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_pipe_tb;
   localparam int WAIT_MAX = 200;
   // Micro-op classes
   localparam int K_ALU = 0;
   localparam int K_BR  = 1;
   localparam int K_MEM = 2;

   logic                  clk;
   logic                  arst_n;
   logic                  flush;
   logic                  ex_valid;
   ex_pkg::alu_op_e       ex_alu_op;
   ex_pkg::bru_op_e       ex_bru_op;
   logic                  ex_lsu_op;
   logic                  ex_epu_op;
   logic [`EX_FE_W-1:0]   ex_fe;
   logic                  ex_pred_taken;
   logic [`EX_PC_W-1:0]   ex_pred_tgt;
   logic [`EX_PC_W-1:0]   ex_pc;
   logic [`EX_DW-1:0]     ex_imm;
   logic [`EX_DW-1:0]     ex_operand1;
   logic [`EX_DW-1:0]     ex_operand2;
   logic [`EX_PRF_AW-1:0] ex_prd;
   logic                  ex_prd_we;
   logic [`EX_ROB_AW-1:0] ex_rob_id;
   logic [`EX_BANK_W-1:0] ex_rob_bank;
   logic                  ex_ready;
   logic                  wb_ready;
   logic                  wb_valid;
   logic [`EX_ROB_AW-1:0] wb_rob_id;
   logic [`EX_BANK_W-1:0] wb_rob_bank;
   logic                  prf_we;
   logic [`EX_PRF_AW-1:0] prf_addr;
   logic [`EX_DW-1:0]     prf_data;
   logic                  wb_fls;
   logic                  wb_exc;
   logic [`EX_AW-1:0]     wb_opera;
   logic [`EX_DW-1:0]     wb_operb;
   logic [`EX_PC_W-1:0]   wb_fls_tgt;

   logic [31:0]           lcg_state;
   logic                  ready_hold;
   int                    errors;
   int                    checks;
   int                    flushed;
   ex_pkg::wb_payload_t   exp_item;
   // Scoreboard, oldest result at the front
   ex_pkg::wb_payload_t   exp_q[$];

   ex_pipe dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic rand_ready();
      logic [31:0] r;
      r = next_rand();
      // Ready in about 70% of the cycles
      return !ready_hold && (r[23:8] % 16'd10 >= 16'd3);
   endfunction

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic abort_run(input string what);
      $display("Timeout: %s within %0d cycles, %0d errors so far", what, WAIT_MAX, errors);
      $display("Verification failed");
      $finish;
   endtask

   // Expected writeback payload of the micro-op now on the inputs
   function automatic ex_pkg::wb_payload_t model_uop();
      ex_pkg::wb_payload_t p;
      logic [`EX_DW-1:0]   opb;
      logic [`EX_DW-1:0]   sum;
      logic [`EX_DW-1:0]   alu;
      logic [`EX_PC_W-1:0] npc;
      logic [`EX_PC_W-1:0] tgt;
      logic [5:0]          sh;
      logic                cond;
      logic                jump;
      logic                taken;
      cond = (ex_bru_op == ex_pkg::BEQ) || (ex_bru_op == ex_pkg::BNE) ||
             (ex_bru_op == ex_pkg::BGT) || (ex_bru_op == ex_pkg::BGTU) ||
             (ex_bru_op == ex_pkg::BLE) || (ex_bru_op == ex_pkg::BLEU);
      jump = (ex_bru_op == ex_pkg::JAL) || (ex_bru_op == ex_pkg::JALR);
      // Immediate goes to the adder for address ops and JALR
      opb = (ex_lsu_op || ex_epu_op || ex_bru_op == ex_pkg::JALR) ? ex_imm : ex_operand2;
      sum = (ex_alu_op == ex_pkg::SUB || cond) ? ex_operand1 - opb : ex_operand1 + opb;
      sh  = ex_operand2[5:0];
      case (ex_alu_op)
         ex_pkg::AND: alu = ex_operand1 & ex_operand2;
         ex_pkg::OR:  alu = ex_operand1 | ex_operand2;
         ex_pkg::XOR: alu = ex_operand1 ^ ex_operand2;
         ex_pkg::SLL: alu = ex_operand1 << sh;
         ex_pkg::SRL: alu = ex_operand1 >> sh;
         ex_pkg::SRA: begin
            alu = ex_operand1 >> sh;
            // Sign fill of the vacated upper bits
            if (`EX_ENABLE_ASR != 0 && ex_operand1[`EX_DW-1])
               alu = alu | ~({`EX_DW{1'b1}} >> sh);
         end
         default:     alu = sum;
      endcase
      case (ex_bru_op)
         ex_pkg::JAL:  taken = 1'b1;
         ex_pkg::JALR: taken = 1'b1;
         ex_pkg::BEQ:  taken = ex_operand1 == ex_operand2;
         ex_pkg::BNE:  taken = ex_operand1 != ex_operand2;
         ex_pkg::BGT:  taken = $signed(ex_operand1) > $signed(ex_operand2);
         ex_pkg::BGTU: taken = ex_operand1 > ex_operand2;
         ex_pkg::BLE:  taken = $signed(ex_operand1) <= $signed(ex_operand2);
         ex_pkg::BLEU: taken = ex_operand1 <= ex_operand2;
         default:      taken = 1'b0;
      endcase
      npc = ex_pc + {{(`EX_PC_W-1){1'b0}}, 1'b1};
      tgt = (ex_bru_op == ex_pkg::JALR) ? sum[`EX_PC_W-1:0] : ex_pc + ex_imm[`EX_PC_W-1:0];
      p.rob_id   = ex_rob_id;
      p.rob_bank = ex_rob_bank;
      p.prf_we   = ex_prd_we && !ex_lsu_op && !ex_epu_op;
      p.prf_addr = ex_prd;
      p.prf_data = jump ? {{(`EX_DW-`EX_PC_W){1'b0}}, npc} : alu;
      p.fls      = (taken != ex_pred_taken) || (taken && tgt != ex_pred_tgt);
      p.exc      = |ex_fe;
      p.opera    = p.exc ? {{(`EX_AW-`EX_FE_W){1'b0}}, ex_fe} : sum;
      p.operb    = ex_operand2;
      p.fls_tgt  = taken ? tgt : npc;
      return p;
   endfunction

   task automatic compare_out(input ex_pkg::wb_payload_t e);
      check_val("wb_rob_id", 64'(wb_rob_id), 64'(e.rob_id));
      check_val("wb_rob_bank", 64'(wb_rob_bank), 64'(e.rob_bank));
      check_val("prf_we", 64'(prf_we), 64'(e.prf_we));
      check_val("prf_addr", 64'(prf_addr), 64'(e.prf_addr));
      check_val("prf_data", 64'(prf_data), 64'(e.prf_data));
      check_val("wb_fls", 64'(wb_fls), 64'(e.fls));
      check_val("wb_exc", 64'(wb_exc), 64'(e.exc));
      check_val("wb_opera", 64'(wb_opera), 64'(e.opera));
      check_val("wb_operb", 64'(wb_operb), 64'(e.operb));
      check_val("wb_fls_tgt", 64'(wb_fls_tgt), 64'(e.fls_tgt));
   endtask

   // Inputs are stable at the falling edge
   always @(negedge clk) begin
      if (arst_n) begin
         check_val("wb_valid", 64'(wb_valid), 64'(exp_q.size() != 0));
         // Free when nothing is held or the held result leaves now
         check_val("ex_ready", 64'(ex_ready), 64'(exp_q.size() == 0 || wb_ready));
         if (flush && wb_valid) begin
            // Held item dropped at the coming edge
            if (exp_q.size() != 0)
               void'(exp_q.pop_front());
         end else if (wb_valid && wb_ready && exp_q.size() != 0) begin
            exp_item = exp_q.pop_front();
            compare_out(exp_item);
         end
         if (ex_valid && ex_ready && !flush)
            exp_q.push_back(model_uop());
      end
   end

   // Drive one micro-op, returns on its accepting edge
   task automatic send_uop(input int kind);
      logic [31:0] r;
      logic [31:0] r2;
      logic [63:0] op1;
      logic [63:0] op2;
      logic [63:0] imm;
      logic [63:0] pc_v;
      logic [63:0] alt;
      int          waited;
      r    = next_rand();
      r2   = next_rand();
      op1  = {next_rand(), next_rand()};
      op2  = {next_rand(), next_rand()};
      imm  = {next_rand(), next_rand()};
      pc_v = {next_rand(), next_rand()};
      alt  = {next_rand(), next_rand()};
      ex_valid      <= 1'b1;
      ex_alu_op     <= (kind == K_ALU) ? ex_pkg::alu_op_e'(r[2:0]) : ex_pkg::ADD;
      ex_bru_op     <= (kind == K_BR) ? ex_pkg::bru_op_e'({1'b0, r[6:4]} + 4'd1) : ex_pkg::NONE;
      ex_lsu_op     <= (kind == K_MEM) && r[7];
      ex_epu_op     <= (kind == K_MEM) && !r[7];
      // Fault code on about one address op in eight
      ex_fe         <= (kind == K_MEM && r[10:8] == 3'd0) ? r[14:11] : '0;
      ex_pred_taken <= r[15];
      ex_pc         <= pc_v[`EX_PC_W-1:0];
      // Right PC-relative target half the time
      ex_pred_tgt   <= r[16] ? pc_v[`EX_PC_W-1:0] + imm[`EX_PC_W-1:0] : alt[`EX_PC_W-1:0];
      ex_imm        <= imm;
      ex_operand1   <= op1;
      // Equal operands now and then for the compares
      ex_operand2   <= (r[18:17] == 2'd0) ? op1 : op2;
      ex_prd        <= r[24:19];
      ex_prd_we     <= r[25];
      ex_rob_id     <= r[29:26];
      ex_rob_bank   <= r2[1:0];
      wb_ready      <= rand_ready();
      waited = 0;
      @(negedge clk);
      while (!ex_ready) begin
         if (waited == WAIT_MAX)
            abort_run("micro-op was not accepted");
         waited++;
         @(posedge clk);
         wb_ready <= rand_ready();
         @(negedge clk);
      end
      @(posedge clk);
   endtask

   task automatic idle_until_empty();
      int waited;
      ex_valid <= 1'b0;
      wb_ready <= rand_ready();
      waited = 0;
      @(negedge clk);
      while (wb_valid) begin
         if (waited == WAIT_MAX)
            abort_run("pipe did not drain");
         waited++;
         @(posedge clk);
         wb_ready <= rand_ready();
         @(negedge clk);
      end
      @(posedge clk);
   endtask

   // Park one item under back-pressure, then flush it
   task automatic flush_held();
      idle_until_empty();
      ready_hold = 1'b1;
      send_uop(int'(next_rand() % 32'd3));
      ex_valid <= 1'b0;
      flush    <= 1'b1;
      wb_ready <= 1'b0;
      @(posedge clk);
      flush <= 1'b0;
      ready_hold = 1'b0;
      flushed++;
   endtask

   initial begin
      lcg_state     = 32'h26d8;
      errors        = 0;
      checks        = 0;
      flushed       = 0;
      ready_hold    = 1'b0;
      arst_n        = 1'b0;
      flush         = 1'b0;
      ex_valid      = 1'b0;
      ex_alu_op     = ex_pkg::ADD;
      ex_bru_op     = ex_pkg::NONE;
      ex_lsu_op     = 1'b0;
      ex_epu_op     = 1'b0;
      ex_fe         = '0;
      ex_pred_taken = 1'b0;
      ex_pred_tgt   = '0;
      ex_pc         = '0;
      ex_imm        = '0;
      ex_operand1   = '0;
      ex_operand2   = '0;
      ex_prd        = '0;
      ex_prd_we     = 1'b0;
      ex_rob_id     = '0;
      ex_rob_bank   = '0;
      wb_ready      = 1'b0;
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;
      repeat (300) send_uop(K_ALU);
      repeat (300) send_uop(K_BR);
      repeat (200) send_uop(K_MEM);
      // Flushes between mixed traffic
      repeat (40) begin
         flush_held();
         send_uop(int'(next_rand() % 32'd3));
      end
      idle_until_empty();
      if (exp_q.size() != 0) begin
         errors++;
         $display("Expected queue still holds %0d results at the end", exp_q.size());
      end
      $display("Checks: %0d, flushes: %0d, errors: %0d", checks, flushed, errors);
      if (errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

/* verilog.f */
+incdir+rtl
rtl/ex_pkg.sv
rtl/ex_add_if.sv
rtl/ex_alu.sv
rtl/ex_bru.sv
rtl/ex_stage_buf.sv
rtl/ex_pipe.sv
dv/ex_pipe_assertions.sv
dv/ex_pipe_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execution pipe testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module ex_pipe_tb

status=0
./obj_dir/Vex_pipe_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Verification failed" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi
echo "Simulation finished cleanly"
